// ==== hdl/car_pkg.sv ====
package car_pkg;

    // PWM timing
    localparam int DUTY_W     = 10;
    localparam int PWM_PERIOD = 1024;
    localparam int CNT_W      = $clog2(PWM_PERIOD);

    // Last count before the counter wraps to 0
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PWM_PERIOD - 1);

    // Wheel speeds as duty values, inner wheel slowed in turns
    localparam logic [DUTY_W-1:0] STRAIGHT_SPEED = 10'd1023;
    localparam logic [DUTY_W-1:0] TURN_IN        = 10'd723;
    localparam logic [DUTY_W-1:0] TURN_OUT       = 10'd1023;
    localparam logic [DUTY_W-1:0] SHARP_IN       = 10'd256;
    localparam logic [DUTY_W-1:0] SHARP_OUT      = 10'd1023;
    localparam logic [DUTY_W-1:0] BACK_SPEED     = 10'd512;

    // Decoded steering decision
    typedef enum logic [2:0] {
        TURN_LEFT   = 3'd0,
        TURN_RIGHT  = 3'd1,
        GO_STRAIGHT = 3'd2,
        SHARP_LEFT  = 3'd3,
        SHARP_RIGHT = 3'd4,
        BACK        = 3'd5
    } steer_mode_t;

    // One bit per reflective sensor, 1 when it sees the line
    typedef struct packed {
        logic left;
        logic centre;
        logic right;
    } line_sense_t;

    // Command for one wheel
    typedef struct packed {
        logic [DUTY_W-1:0] duty;
        logic              fwd;     // 1 for forward
    } wheel_cmd_t;

    // H-bridge outputs
    typedef struct packed {
        logic left_pwm;
        logic right_pwm;
        logic left_fwd;
        logic right_fwd;
    } drive_t;

endpackage

// ==== hdl/tracker_sensor.sv ====
`timescale 1ns/1ps

module tracker_sensor (
    input  logic                 clk,
    input  logic                 reset,
    input  car_pkg::line_sense_t sensor,
    output car_pkg::steer_mode_t mode
);

    car_pkg::line_sense_t sync_1;   // First synchronizer stage
    car_pkg::line_sense_t sync_2;   // Stable copy of the sensors
    car_pkg::steer_mode_t next_mode;

    // Sensors are asynchronous to clk
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_1 <= '{left: 1'b0, centre: 1'b1, right: 1'b0};    // Straight, as the reset mode
            sync_2 <= '{left: 1'b0, centre: 1'b1, right: 1'b0};
        end else begin
            sync_1 <= sensor;
            sync_2 <= sync_1;
        end
    end

    // Pattern is left, centre, right from MSB down
    always_comb begin
        next_mode = mode;   // Hold on 101
        case (sync_2)
            3'b010,
            3'b111: begin
                next_mode = car_pkg::GO_STRAIGHT;
            end
            3'b110: begin
                next_mode = car_pkg::TURN_LEFT;
            end
            3'b100: begin
                next_mode = car_pkg::SHARP_LEFT;
            end
            3'b011: begin
                next_mode = car_pkg::TURN_RIGHT;
            end
            3'b001: begin
                next_mode = car_pkg::SHARP_RIGHT;
            end
            3'b000: begin
                next_mode = car_pkg::BACK;  // Line lost
            end
            default: begin
                next_mode = mode;   // Crossing mark, keep last decision
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode <= car_pkg::GO_STRAIGHT;
        end else begin
            mode <= next_mode;
        end
    end

endmodule

// ==== hdl/motor_speed.sv ====
`timescale 1ns/1ps

module motor_speed (
    input  logic                 clk,
    input  logic                 reset,
    input  car_pkg::steer_mode_t mode,
    output car_pkg::wheel_cmd_t  left_cmd,
    output car_pkg::wheel_cmd_t  right_cmd
);

    car_pkg::wheel_cmd_t next_left;
    car_pkg::wheel_cmd_t next_right;

    // Speed table, inner wheel slowed in turns
    always_comb begin
        next_left  = '{duty: car_pkg::STRAIGHT_SPEED, fwd: 1'b1};
        next_right = '{duty: car_pkg::STRAIGHT_SPEED, fwd: 1'b1};
        case (mode)
            car_pkg::TURN_LEFT: begin
                next_left.duty  = car_pkg::TURN_IN;
                next_right.duty = car_pkg::TURN_OUT;
            end
            car_pkg::TURN_RIGHT: begin
                next_left.duty  = car_pkg::TURN_OUT;
                next_right.duty = car_pkg::TURN_IN;
            end
            car_pkg::SHARP_LEFT: begin
                next_left.duty  = car_pkg::SHARP_IN;
                next_right.duty = car_pkg::SHARP_OUT;
            end
            car_pkg::SHARP_RIGHT: begin
                next_left.duty  = car_pkg::SHARP_OUT;
                next_right.duty = car_pkg::SHARP_IN;
            end
            car_pkg::BACK: begin
                // Both wheels reverse to find the line again
                next_left  = '{duty: car_pkg::BACK_SPEED, fwd: 1'b0};
                next_right = '{duty: car_pkg::BACK_SPEED, fwd: 1'b0};
            end
            default: begin
                next_left.duty  = car_pkg::STRAIGHT_SPEED;
                next_right.duty = car_pkg::STRAIGHT_SPEED;
            end
        endcase
    end

    // Wheels stopped but pointed forward out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            left_cmd  <= '{duty: '0, fwd: 1'b1};
            right_cmd <= '{duty: '0, fwd: 1'b1};
        end else begin
            left_cmd  <= next_left;
            right_cmd <= next_right;
        end
    end

endmodule

// ==== hdl/pwm_gen.sv ====
`timescale 1ns/1ps

module pwm_gen (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [car_pkg::DUTY_W-1:0] duty,
    output logic                       pwm
);

    logic [car_pkg::CNT_W-1:0]  count;
    logic [car_pkg::DUTY_W-1:0] duty_q;     // Duty for the running period
    logic                       wrap;

    assign wrap = (count == car_pkg::CNT_LAST);

    // Free-running period counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // New duty only at the period boundary so no pulse is clipped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_q <= '0;
        end else if (wrap) begin
            duty_q <= duty;
        end
    end

    // High for exactly duty_q cycles from count 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (count < duty_q);
        end
    end

endmodule

// ==== hdl/car_top.sv ====
`timescale 1ns/1ps

module car_top (
    input  logic                 clk,
    input  logic                 reset,
    input  car_pkg::line_sense_t sensor,
    output car_pkg::drive_t      drive
);

    car_pkg::steer_mode_t mode;
    car_pkg::wheel_cmd_t  left_cmd;
    car_pkg::wheel_cmd_t  right_cmd;
    logic                 left_pwm;
    logic                 right_pwm;

    tracker_sensor i_tracker (
        .clk    (clk),
        .reset  (reset),
        .sensor (sensor),
        .mode   (mode)
    );

    motor_speed i_speed (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .left_cmd  (left_cmd),
        .right_cmd (right_cmd)
    );

    pwm_gen i_pwm_left (
        .clk   (clk),
        .reset (reset),
        .duty  (left_cmd.duty),
        .pwm   (left_pwm)
    );

    pwm_gen i_pwm_right (
        .clk   (clk),
        .reset (reset),
        .duty  (right_cmd.duty),
        .pwm   (right_pwm)
    );

    // Direction bits go straight to the bridge inputs
    assign drive = '{
        left_pwm:  left_pwm,
        right_pwm: right_pwm,
        left_fwd:  left_cmd.fwd,
        right_fwd: right_cmd.fwd
    };

endmodule

// ==== testbench/car_assert.sv ====
`timescale 1ns/1ps

module car_assert (
    input logic                       clk,
    input logic                       reset,
    input car_pkg::drive_t            drive,
    input logic [car_pkg::CNT_W-1:0]  left_count,
    input logic [car_pkg::DUTY_W-1:0] left_duty_q,
    input logic                       left_pwm,
    input logic [car_pkg::CNT_W-1:0]  right_count,
    input logic [car_pkg::DUTY_W-1:0] right_duty_q,
    input logic                       right_pwm
);

    // PWM off, wheels pointed forward
    a_reset_drive: assert property (@(posedge clk)
        reset |-> (drive == 4'b0011))
        else $error("drive is not idle while reset is high");

    a_fwd_match: assert property (@(posedge clk)
        drive.right_fwd == drive.left_fwd)
        else $error("right_fwd differs from left_fwd");

    // Period start with zero duty keeps the output low
    a_left_zero: assert property (@(posedge clk) disable iff (reset)
        (left_count == '0 && left_duty_q == '0) |=> !left_pwm)
        else $error("left PWM high in a period with duty 0");

    a_right_zero: assert property (@(posedge clk) disable iff (reset)
        (right_count == '0 && right_duty_q == '0) |=> !right_pwm)
        else $error("right PWM high in a period with duty 0");

endmodule

// ==== testbench/car_tb.sv ====
`timescale 1ns/1ps

module car_tb;

    localparam real CLK_PERIOD    = 100.0;
    localparam int  PERIOD        = car_pkg::PWM_PERIOD;
    localparam int  SETTLE_CYCLES = 2 * car_pkg::PWM_PERIOD + 8;
    localparam int  MAX_WORDS     = 256;
    localparam int  WORDS_PER_VEC = 5;

    logic                 clk;
    logic                 reset;
    car_pkg::line_sense_t sensor;
    car_pkg::drive_t      drive;

    logic [15:0] stim_mem [0:MAX_WORDS-1];
    int          n_vec;
    bit          loaded;
    int          errors;
    int          checks;
    int          cur_vec;

    car_top i_dut (
        .clk    (clk),
        .reset  (reset),
        .sensor (sensor),
        .drive  (drive)
    );

    // Assertions see the PWM internals from inside car_top
    bind car_top car_assert i_assert (
        .clk          (clk),
        .reset        (reset),
        .drive        (drive),
        .left_count   (i_pwm_left.count),
        .left_duty_q  (i_pwm_left.duty_q),
        .left_pwm     (left_pwm),
        .right_count  (i_pwm_right.count),
        .right_duty_q (i_pwm_right.duty_q),
        .right_pwm    (right_pwm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    task check_value(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            $display("[FAIL] %s exp %0h got %0h (vector %0d)", name, exp, got, cur_vec);
            errors++;
        end
    endtask

    task check_either(input string name, input int old_v, input int new_v, input int got);
        checks++;
        assert (got == old_v || got == new_v) else begin
            $display("[FAIL] %s exp %0h or %0h got %0h (vector %0d)",
                     name, old_v, new_v, got, cur_vec);
            errors++;
        end
    endtask

    // One hex digit per sensor, left digit is the left sensor
    task drive_sensor(input logic [15:0] pattern);
        @(posedge clk);
        #5;
        sensor = '{left: pattern[8], centre: pattern[4], right: pattern[0]};
    endtask

    task check_after_reset;
        int i;
        int high_l;
        int high_r;
        int fwd_l;
        int fwd_r;
        high_l = 0;
        high_r = 0;
        fwd_l  = 0;
        fwd_r  = 0;
        for (i = 0; i < PERIOD; i++) begin
            @(negedge clk);
            high_l += drive.left_pwm;
            high_r += drive.right_pwm;
            fwd_l  += drive.left_fwd;
            fwd_r  += drive.right_fwd;
        end
        check_value("left_pwm high cycles after reset", 0, high_l);
        check_value("right_pwm high cycles after reset", 0, high_r);
        check_value("left_fwd cycles after reset", PERIOD, fwd_l);
        check_value("right_fwd cycles after reset", PERIOD, fwd_r);
    endtask

    // Called right after a negedge, returns on the first high sample of a period
    task align_left_period;
        logic prev;
        bit   found;
        int   n;
        found = 1'b0;
        n     = 0;
        prev  = drive.left_pwm;
        while (!found && n < PERIOD + 2) begin
            @(negedge clk);
            n++;
            found = !prev && drive.left_pwm;
            prev  = drive.left_pwm;
        end
    endtask

    // Sensor change halfway through a measured period, then settle
    task apply_mid_period(input logic [15:0] pattern,
                          input int old_l, input int old_r,
                          input int new_l, input int new_r);
        int i;
        int high_l;
        int high_r;
        align_left_period();
        high_l = 0;
        high_r = 0;
        for (i = 0; i < PERIOD; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            high_l += drive.left_pwm;
            high_r += drive.right_pwm;
            if (i == PERIOD / 2) begin
                drive_sensor(pattern);
            end
        end
        check_either("left_duty first period", old_l, new_l, high_l);
        check_either("right_duty first period", old_r, new_r, high_r);
        repeat (SETTLE_CYCLES - (PERIOD - 1 - PERIOD / 2)) @(negedge clk);
    endtask

    task measure_period(output int high_l, output int high_r);
        int n;
        align_left_period();
        high_l = 0;
        high_r = 0;
        for (n = 0; n < PERIOD; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            high_l += drive.left_pwm;
            high_r += drive.right_pwm;
        end
    endtask

    task run_vectors;
        int          v;
        int          base;
        int          exp_l;
        int          exp_r;
        int          old_l;
        int          old_r;
        int          high_l;
        int          high_r;
        logic [15:0] pattern;
        old_l = stim_mem[2];    // Car already runs straight before vector 0
        old_r = stim_mem[3];
        for (v = 0; v < n_vec; v++) begin
            cur_vec = v;
            base    = 1 + WORDS_PER_VEC * v;
            pattern = stim_mem[base];
            exp_l   = stim_mem[base + 1];
            exp_r   = stim_mem[base + 2];
            apply_mid_period(pattern, old_l, old_r, exp_l, exp_r);
            measure_period(high_l, high_r);
            check_value("left_duty", exp_l, high_l);
            check_value("right_duty", exp_r, high_r);
            check_value("left_fwd", stim_mem[base + 3], drive.left_fwd);
            check_value("right_fwd", stim_mem[base + 4], drive.right_fwd);
            old_l = exp_l;
            old_r = exp_r;
        end
    endtask

    initial begin
        sensor  = '{left: 1'b0, centre: 1'b1, right: 1'b0};
        reset   = 1'b1;
        errors  = 0;
        checks  = 0;
        cur_vec = -1;
        n_vec   = 0;
        loaded  = 1'b0;
        $readmemh("testbench/car_stim.txt", stim_mem);
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        if ($isunknown(stim_mem[0]) || stim_mem[0] == 0 ||
            1 + WORDS_PER_VEC * stim_mem[0] > MAX_WORDS) begin
            $display("Error: the stim file could not be read or holds no usable vectors");
            errors++;
        end else begin
            n_vec  = stim_mem[0];
            loaded = 1'b1;
            check_after_reset();
            run_vectors();
        end
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // About four PWM periods per vector plus the reset period
    initial begin
        wait (loaded);
        #((n_vec * 4 + 4) * PERIOD * CLK_PERIOD);
        errors++;
        $display("Error: simulation timed out while waiting for the PWM outputs");
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== testbench/car_stim.txt ====
// First word: vector count. Then one vector per line, all hex:
// sensor (one digit each for left centre right) left_duty right_duty left_fwd right_fwd
12
// Straight and hold after straight
010 3ff 3ff 1 1
111 3ff 3ff 1 1
101 3ff 3ff 1 1
// Turn left, then crossing mark
110 2d3 3ff 1 1
101 2d3 3ff 1 1
// Turn right, then crossing mark
011 3ff 2d3 1 1
101 3ff 2d3 1 1
// Sharp left, then crossing mark
100 100 3ff 1 1
101 100 3ff 1 1
// Sharp right, then crossing mark
001 3ff 100 1 1
101 3ff 100 1 1
// Line lost, both wheels reverse
000 200 200 0 0
101 200 200 0 0
// Large jumps between modes
010 3ff 3ff 1 1
100 100 3ff 1 1
000 200 200 0 0
011 3ff 2d3 1 1
111 3ff 3ff 1 1

// ==== vlog.f ====
hdl/car_pkg.sv
hdl/tracker_sensor.sv
hdl/motor_speed.sv
hdl/pwm_gen.sv
hdl/car_top.sv
testbench/car_assert.sv
testbench/car_tb.sv

// ==== Bender.yml ====
package:
  name: line_car

sources:
  - hdl/car_pkg.sv
  - hdl/tracker_sensor.sv
  - hdl/motor_speed.sv
  - hdl/pwm_gen.sv
  - hdl/car_top.sv
  - target: test
    files:
      - testbench/car_assert.sv
      - testbench/car_tb.sv
